//--- source/axi_sram_settings.svh
`ifndef AXI_SRAM_SETTINGS_SVH
`define AXI_SRAM_SETTINGS_SVH

// AXI byte address width
`define AXI_ADDR_WIDTH 20

// AXI data bus width in bits
`define AXI_DATA_WIDTH 16

// AXI transaction id width
`define AXI_ID_WIDTH 4

// One strobe bit per data byte
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)

// Byte offset bits inside one SRAM word
`define SRAM_LSB ($clog2(`AXI_STRB_WIDTH))

// SRAM word address width
`define SRAM_ADDR_WIDTH (`AXI_ADDR_WIDTH - `SRAM_LSB)

`endif

//--- source/axi_sram_pkg.sv
`default_nettype none

`include "axi_sram_settings.svh"

package axi_sram_pkg;

  // AXI burst type encoding
  typedef enum logic [1:0] {
    burst_fixed    = 2'b00,
    burst_incr     = 2'b01,
    burst_wrap     = 2'b10,
    burst_reserved = 2'b11
  } axi_burst_e;

  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic [`AXI_ADDR_WIDTH-1:0] addr;   // Byte address
    logic [7:0]                 len;    // Beats minus one
    axi_burst_e                 burst;
  } aw_beat_t;

  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0] data;
    logic [`AXI_STRB_WIDTH-1:0] strb;
    logic                       last;
  } w_beat_t;

  typedef struct packed {
    logic [`SRAM_ADDR_WIDTH-1:0] addr;  // Word address
    logic [`AXI_DATA_WIDTH-1:0]  data;
    logic [`AXI_STRB_WIDTH-1:0]  strb;
  } sram_wr_cmd_t;

  typedef struct packed {
    logic [`AXI_ID_WIDTH-1:0] id;
    logic [1:0]               resp;
  } b_rsp_t;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

//--- source/stream_slice.sv
`default_nettype none

module stream_slice import axi_sram_pkg::*; #(
  parameter type payload_t = w_beat_t
) (
  input  wire      clk,
  input  wire      rst_n,
  input  wire      in_valid,
  output logic     in_ready,
  input  wire      payload_t in_data,
  output logic     out_valid,
  input  wire      out_ready,
  output payload_t out_data
);

  payload_t main_q;
  payload_t skid_q;
  logic     main_valid_q;
  logic     skid_valid_q;
  logic     main_valid_d;
  logic     skid_valid_d;
  logic     advance;   // Main register is free to take a new item
  logic     in_fire;

  assign advance   = out_ready | ~main_valid_q;
  assign in_fire   = in_valid & in_ready;
  assign out_valid = main_valid_q;
  assign out_data  = main_q;

  always_comb begin
    main_valid_d = main_valid_q;
    skid_valid_d = skid_valid_q;
    if (advance) begin
      main_valid_d = skid_valid_q | in_fire;  // Skid drains first
      skid_valid_d = 1'b0;
    end else if (in_fire) begin
      skid_valid_d = 1'b1;  // Park the item while the output stalls
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
      in_ready     <= 1'b0;
    end else begin
      main_valid_q <= main_valid_d;
      skid_valid_q <= skid_valid_d;
      in_ready     <= ~skid_valid_d;  // Low only with both entries full
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      main_q <= skid_valid_q ? skid_q : in_data;
    end
    if (in_fire && !advance) begin
      skid_q <= in_data;
    end
  end

endmodule

`default_nettype wire

//--- source/axi_burst_walker.sv
`default_nettype none

`include "axi_sram_settings.svh"

module axi_burst_walker import axi_sram_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  input  wire          aw_valid,
  output logic         aw_ready,
  input  wire          aw_beat_t aw,
  input  wire          w_valid,
  output logic         w_ready,
  input  wire          w_beat_t w,
  output logic         cmd_valid,
  input  wire          cmd_ready,
  output sram_wr_cmd_t cmd,
  output logic         rsp_valid,
  input  wire          rsp_ready,
  output b_rsp_t       rsp
);

  logic                        busy_q;      // Burst in progress
  logic                        w_done_q;    // All counted beats taken
  logic [`SRAM_ADDR_WIDTH-1:0] addr_q;
  logic [7:0]                  beats_left_q;
  axi_burst_e                  burst_q;
  logic [`AXI_ID_WIDTH-1:0]    id_q;
  logic                        err_q;
  logic                        err_d;
  logic                        cmd_last_q;  // Command holds the final beat
  logic                        writable;
  logic                        last_beat;
  logic                        aw_fire;
  logic                        w_fire;
  logic                        cmd_fire;

  // Only FIXED and INCR reach the SRAM
  assign writable  = (burst_q == burst_incr) || (burst_q == burst_fixed);
  assign last_beat = (beats_left_q == 8'd0);

  assign aw_ready = ~busy_q & ~rsp_valid;
  assign w_ready  = busy_q & ~w_done_q & (~writable | ~cmd_valid | cmd_ready);

  assign aw_fire  = aw_valid & aw_ready;
  assign w_fire   = w_valid & w_ready;
  assign cmd_fire = cmd_valid & cmd_ready;

  // wlast must agree with the beat count
  assign err_d = err_q | (w_fire & (w.last != last_beat));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      w_done_q  <= 1'b0;
      err_q     <= 1'b0;
      cmd_valid <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      if (aw_fire) begin
        busy_q   <= 1'b1;
        w_done_q <= 1'b0;
        err_q    <= 1'b0;
      end else begin
        err_q <= err_d;
      end

      if (w_fire && last_beat) begin
        w_done_q <= 1'b1;
      end

      if (w_fire && writable) begin
        cmd_valid <= 1'b1;
      end else if (cmd_fire) begin
        cmd_valid <= 1'b0;
      end

      if (rsp_valid && rsp_ready) begin
        rsp_valid <= 1'b0;
      end

      // Burst ends on the last command taken or the last beat drained
      if ((cmd_fire && cmd_last_q) || (w_fire && last_beat && !writable)) begin
        busy_q    <= 1'b0;
        rsp_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      addr_q       <= aw.addr[`AXI_ADDR_WIDTH-1:`SRAM_LSB];
      beats_left_q <= aw.len;
      burst_q      <= aw.burst;
      id_q         <= aw.id;
    end else if (w_fire) begin
      beats_left_q <= beats_left_q - 8'd1;
      if (burst_q == burst_incr) begin
        addr_q <= addr_q + 1'b1;
      end
    end

    if (w_fire && writable) begin
      cmd.addr   <= addr_q;
      cmd.data   <= w.data;
      cmd.strb   <= w.strb;
      cmd_last_q <= last_beat;
    end

    if ((cmd_fire && cmd_last_q) || (w_fire && last_beat && !writable)) begin
      rsp.id   <= id_q;
      rsp.resp <= (err_d || !writable) ? resp_slverr : resp_okay;
    end
  end

endmodule

`default_nettype wire

//--- source/axi_write_response.sv
`default_nettype none

`include "axi_sram_settings.svh"

module axi_write_response import axi_sram_pkg::*; (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           rsp_valid,
  output logic                          rsp_ready,
  input  wire b_rsp_t                   rsp,
  output logic                          bvalid,
  input  wire                           bready,
  output logic [`AXI_ID_WIDTH-1:0]      bid,
  output logic [1:0]                    bresp
);

  logic load;

  // Refill while the held beat leaves
  assign rsp_ready = ~bvalid | bready;
  assign load      = rsp_valid & rsp_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      bresp  <= 2'b00;
    end else if (load) begin
      bvalid <= 1'b1;
      bresp  <= rsp.resp;
    end else if (bready) begin
      bvalid <= 1'b0;
      bresp  <= 2'b00;  // Idle B shows OKAY
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      bid <= rsp.id;
    end
  end

endmodule

`default_nettype wire

//--- source/axi_sram_wr.sv
`default_nettype none

`include "axi_sram_settings.svh"

module axi_sram_wr import axi_sram_pkg::*; (
  input  wire                         clk,
  input  wire                         rst_n,

  input  wire                         awvalid,
  output logic                        awready,
  input  wire [`AXI_ID_WIDTH-1:0]     awid,
  input  wire [`AXI_ADDR_WIDTH-1:0]   awaddr,
  input  wire [7:0]                   awlen,
  input  wire [1:0]                   awburst,

  input  wire                         wvalid,
  output logic                        wready,
  input  wire [`AXI_DATA_WIDTH-1:0]   wdata,
  input  wire [`AXI_STRB_WIDTH-1:0]   wstrb,
  input  wire                         wlast,

  output logic                        bvalid,
  input  wire                         bready,
  output logic [`AXI_ID_WIDTH-1:0]    bid,
  output logic [1:0]                  bresp,

  output sram_wr_cmd_t                sram_cmd,
  output logic                        sram_cmd_valid,
  input  wire                         sram_cmd_ready
);

  aw_beat_t aw_port;
  w_beat_t  w_port;

  aw_beat_t aw_in;
  logic     aw_in_valid;
  logic     aw_in_ready;
  w_beat_t  w_in;
  logic     w_in_valid;
  logic     w_in_ready;
  b_rsp_t   rsp;
  logic     rsp_valid;
  logic     rsp_ready;

  // Port fields into beat structs
  assign aw_port.id    = awid;
  assign aw_port.addr  = awaddr;
  assign aw_port.len   = awlen;
  assign aw_port.burst = axi_burst_e'(awburst);

  assign w_port.data = wdata;
  assign w_port.strb = wstrb;
  assign w_port.last = wlast;

  stream_slice #(
    .payload_t(aw_beat_t)
  ) u_aw_slice (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (awvalid),
    .in_ready (awready),
    .in_data  (aw_port),
    .out_valid(aw_in_valid),
    .out_ready(aw_in_ready),
    .out_data (aw_in)
  );

  stream_slice #(
    .payload_t(w_beat_t)
  ) u_w_slice (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (wvalid),
    .in_ready (wready),
    .in_data  (w_port),
    .out_valid(w_in_valid),
    .out_ready(w_in_ready),
    .out_data (w_in)
  );

  axi_burst_walker u_walker (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_valid (aw_in_valid),
    .aw_ready (aw_in_ready),
    .aw       (aw_in),
    .w_valid  (w_in_valid),
    .w_ready  (w_in_ready),
    .w        (w_in),
    .cmd_valid(sram_cmd_valid),
    .cmd_ready(sram_cmd_ready),
    .cmd      (sram_cmd),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp      (rsp)
  );

  axi_write_response u_response (
    .clk      (clk),
    .rst_n    (rst_n),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp      (rsp),
    .bvalid   (bvalid),
    .bready   (bready),
    .bid      (bid),
    .bresp    (bresp)
  );

endmodule

`default_nettype wire

//--- dv/axi_sram_wr_tb.sv
`default_nettype none

`include "axi_sram_settings.svh"

module axi_sram_wr_tb import axi_sram_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_wait = 500;  // Cycles per wait loop

  typedef w_beat_t beat_q_t[$];

  logic                        clk;
  logic                        rst_n;
  logic                        awvalid;
  logic                        awready;
  logic [`AXI_ID_WIDTH-1:0]    awid;
  logic [`AXI_ADDR_WIDTH-1:0]  awaddr;
  logic [7:0]                  awlen;
  logic [1:0]                  awburst;
  logic                        wvalid;
  logic                        wready;
  logic [`AXI_DATA_WIDTH-1:0]  wdata;
  logic [`AXI_STRB_WIDTH-1:0]  wstrb;
  logic                        wlast;
  logic                        bvalid;
  logic                        bready;
  logic [`AXI_ID_WIDTH-1:0]    bid;
  logic [1:0]                  bresp;
  sram_wr_cmd_t                sram_cmd;
  logic                        sram_cmd_valid;
  logic                        sram_cmd_ready;

  logic         random_ready;  // Toggle SRAM and B back-pressure
  int           mismatch_count;
  int           other_count;
  sram_wr_cmd_t exp_cmd_q[$];
  b_rsp_t       exp_rsp_q[$];
  sram_wr_cmd_t exp_cmd;
  b_rsp_t       exp_rsp;

  axi_sram_wr u_axi_sram_wr (
    .clk           (clk),
    .rst_n         (rst_n),
    .awvalid       (awvalid),
    .awready       (awready),
    .awid          (awid),
    .awaddr        (awaddr),
    .awlen         (awlen),
    .awburst       (awburst),
    .wvalid        (wvalid),
    .wready        (wready),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wlast         (wlast),
    .bvalid        (bvalid),
    .bready        (bready),
    .bid           (bid),
    .bresp         (bresp),
    .sram_cmd      (sram_cmd),
    .sram_cmd_valid(sram_cmd_valid),
    .sram_cmd_ready(sram_cmd_ready)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    #1;
    sram_cmd_ready = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
    bready         = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
  end

  // Expected SRAM commands and B response for one AW and its W beats
  function automatic void predict(input aw_beat_t aw, input beat_q_t beats,
                                  output sram_wr_cmd_t cmds[$], output b_rsp_t rsp);
    logic [`SRAM_ADDR_WIDTH-1:0] word;
    logic                        writable;
    logic                        err;
    sram_wr_cmd_t                cmd;
    cmds     = {};
    word     = `SRAM_ADDR_WIDTH'(aw.addr >> `SRAM_LSB);
    writable = (aw.burst == burst_incr) || (aw.burst == burst_fixed);
    err      = !writable;
    foreach (beats[i]) begin
      if (beats[i].last != (i == int'(aw.len))) begin
        err = 1'b1;
      end
      cmd.addr = word;
      cmd.data = beats[i].data;
      cmd.strb = beats[i].strb;
      if (writable) begin
        cmds.push_back(cmd);
      end
      if (aw.burst == burst_incr) begin
        word = word + 1'b1;
      end
    end
    rsp.id   = aw.id;
    rsp.resp = err ? resp_slverr : resp_okay;
  endfunction

  function automatic beat_q_t make_beats(input int count, input int last_at, input bit full);
    beat_q_t beats;
    w_beat_t b;
    for (int i = 0; i < count; i++) begin
      b.data = `AXI_DATA_WIDTH'($urandom);
      b.strb = full ? '1 : `AXI_STRB_WIDTH'($urandom);
      b.last = (i == last_at);
      beats.push_back(b);
    end
    return beats;
  endfunction

  function automatic aw_beat_t make_aw(input int id, input int addr, input int len,
                                       input axi_burst_e burst);
    aw_beat_t aw;
    aw.id    = `AXI_ID_WIDTH'(id);
    aw.addr  = `AXI_ADDR_WIDTH'(addr);
    aw.len   = 8'(len);
    aw.burst = burst;
    return aw;
  endfunction

  task automatic end_run();
    $display("mismatches: %0d, other errors: %0d", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    other_count++;
    $display("timeout at %0t while waiting for %s", $time, what);
    end_run();
  endtask

  task automatic send_aw(input aw_beat_t aw);
    int waited;
    waited  = 0;
    awvalid = 1'b1;
    awid    = aw.id;
    awaddr  = aw.addr;
    awlen   = aw.len;
    awburst = aw.burst;
    do begin
      @(posedge clk);
      waited++;
      if (waited > max_wait) begin
        report_timeout("awready");
      end
    end while (!awready);
    #1 awvalid = 1'b0;
  endtask

  task automatic send_w(input beat_q_t beats);
    int waited;
    foreach (beats[i]) begin
      waited = 0;
      wvalid = 1'b1;
      wdata  = beats[i].data;
      wstrb  = beats[i].strb;
      wlast  = beats[i].last;
      do begin
        @(posedge clk);
        waited++;
        if (waited > max_wait) begin
          report_timeout("wready");
        end
      end while (!wready);
      #1 wvalid = 1'b0;
    end
  endtask

  // Record the expectation first, then play the burst
  task automatic run_txn(input aw_beat_t aw, input beat_q_t beats);
    sram_wr_cmd_t cmds[$];
    b_rsp_t       rsp;
    predict(aw, beats, cmds, rsp);
    foreach (cmds[i]) begin
      exp_cmd_q.push_back(cmds[i]);
    end
    exp_rsp_q.push_back(rsp);
    send_aw(aw);
    send_w(beats);
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (exp_cmd_q.size() != 0 || exp_rsp_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > max_wait) begin
        report_timeout("outstanding commands and responses to drain");
      end
    end
    @(posedge clk);
    #1;
  endtask

  always @(posedge clk) begin
    if (sram_cmd_valid && sram_cmd_ready) begin
      if (exp_cmd_q.size() == 0) begin
        other_count++;
        $display("unexpected SRAM command at %0t, addr %h", $time, sram_cmd.addr);
      end else begin
        exp_cmd = exp_cmd_q.pop_front();
        if (sram_cmd !== exp_cmd) begin
          mismatch_count++;
          $display("mismatch at %0t: sram_cmd %h/%h/%h, expected %h/%h/%h", $time,
                   sram_cmd.addr, sram_cmd.data, sram_cmd.strb,
                   exp_cmd.addr, exp_cmd.data, exp_cmd.strb);
        end
      end
    end
    if (bvalid && bready) begin
      if (exp_rsp_q.size() == 0) begin
        other_count++;
        $display("unexpected B response at %0t, id %h", $time, bid);
      end else begin
        exp_rsp = exp_rsp_q.pop_front();
        if (bid !== exp_rsp.id || bresp !== exp_rsp.resp) begin
          mismatch_count++;
          $display("mismatch at %0t: B id %h resp %b, expected id %h resp %b", $time,
                   bid, bresp, exp_rsp.id, exp_rsp.resp);
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h9d3b_2a56));
    clk            = 1'b0;
    rst_n          = 1'b0;
    awvalid        = 1'b0;
    awid           = '0;
    awaddr         = '0;
    awlen          = '0;
    awburst        = '0;
    wvalid         = 1'b0;
    wdata          = '0;
    wstrb          = '0;
    wlast          = 1'b0;
    bready         = 1'b1;
    sram_cmd_ready = 1'b1;
    random_ready   = 1'b0;
    mismatch_count = 0;
    other_count    = 0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    // Idle outputs right after reset
    if (sram_cmd_valid !== 1'b0 || bvalid !== 1'b0 || bresp !== 2'b00) begin
      mismatch_count++;
      $display("mismatch at %0t: after reset cmd_valid %b bvalid %b bresp %b", $time,
               sram_cmd_valid, bvalid, bresp);
    end

    run_txn(make_aw(1, 'h00404, 0, burst_incr), make_beats(1, 0, 1'b1));
    wait_idle();

    begin : incr_and_fixed
      int len;
      len = $urandom_range(7, 1);
      run_txn(make_aw(2, 'h01000, len, burst_incr), make_beats(len + 1, len, 1'b0));
      len = $urandom_range(7, 1);
      run_txn(make_aw(3, 'h02222, len, burst_fixed), make_beats(len + 1, len, 1'b0));
      wait_idle();
    end

    // Back-to-back traffic under random back-pressure
    random_ready = 1'b1;
    for (int i = 0; i < 6; i++) begin
      int len;
      len = $urandom_range(7, 0);
      run_txn(make_aw(i + 4, 'h04000 + i * 'h40, len, (i % 3 == 2) ? burst_fixed : burst_incr),
              make_beats(len + 1, len, 1'b0));
    end
    wait_idle();

    run_txn(make_aw(10, 'h08000, 3, burst_wrap), make_beats(4, 3, 1'b1));
    run_txn(make_aw(11, 'h08100, 2, burst_incr), make_beats(3, 2, 1'b1));
    wait_idle();

    // wlast one beat early
    run_txn(make_aw(12, 'h09000, 4, burst_incr), make_beats(5, 3, 1'b1));
    wait_idle();

    end_run();
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+source
source/axi_sram_pkg.sv
source/stream_slice.sv
source/axi_burst_walker.sv
source/axi_write_response.sv
source/axi_sram_wr.sv
dv/axi_sram_wr_tb.sv

//--- Bender.yml
package:
  name: axi_sram_wr

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/axi_sram_pkg.sv
      - source/stream_slice.sv
      - source/axi_burst_walker.sv
      - source/axi_write_response.sv
      - source/axi_sram_wr.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/axi_sram_wr_tb.sv
